/* design/pwo_config.svh */
/*
 * Pointwise engine configuration
 * Coefficient and memory geometry, and the modulus q = 2^23 - 2^13 + 1
 */
`ifndef PWO_CONFIG_SVH
`define PWO_CONFIG_SVH

// Coefficient value and its slot in a memory word
`define PWO_COEFF_WIDTH 23
`define PWO_SLOT_WIDTH  24

// Coefficients handled per beat, and per polynomial
`define PWO_LANES 4
`define PWO_N     256

// Modulus
`define PWO_Q 23'd8380417

// Word address into the coefficient memory
`define PWO_ADDR_WIDTH 15

`endif

/* design/pwo_pkg.sv */
/*
 * Pointwise engine types
 * Shared vectors, the operation enum and the structs passed between stages
 */
`include "pwo_config.svh"

package pwo_pkg;

    typedef logic [`PWO_COEFF_WIDTH-1:0]                 coeff_t;
    typedef logic [`PWO_LANES*`PWO_SLOT_WIDTH-1:0]        mem_word_t;
    typedef logic [`PWO_ADDR_WIDTH-1:0]                  mem_addr_t;
    typedef logic [$clog2(`PWO_N/`PWO_LANES)-1:0]        beat_idx_t;

    typedef enum logic [1:0] {
        pwo_mul,
        pwo_add,
        pwo_sub
    } pwo_mode_e;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } pwo_bases_t;

    typedef struct packed {
        pwo_mode_e mode;
        logic      add_c;
    } lane_op_t;

    // Rides along with every beat down the pipe
    typedef struct packed {
        logic      valid;
        lane_op_t  op;
        mem_addr_t wr_addr;
    } beat_tag_t;

    typedef struct packed {
        beat_tag_t tag;
        coeff_t    a;
        coeff_t    b;
        coeff_t    c;
    } lane_in_t;

    typedef struct packed {
        beat_tag_t tag;
        coeff_t    res;
    } lane_out_t;

endpackage

/* design/pwo_ctrl.sv */
/*
 * Pointwise pass sequencer
 * Issues 64 read beats gated by the sampler strobe, tags each beat,
 * then waits for the matching writes before signalling done
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_ctrl (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  pwo_pkg::pwo_mode_e    mode_i,
    input  logic                  accumulate_i,
    input  pwo_pkg::pwo_bases_t   bases_i,
    input  logic                  sampler_valid_i,
    input  logic                  wr_strobe_i,
    output pwo_pkg::mem_req_t     rd_req_a_o,
    output pwo_pkg::mem_req_t     rd_req_b_o,
    output pwo_pkg::mem_req_t     rd_req_c_o,
    output pwo_pkg::beat_tag_t    tag_o,
    output logic                  busy_o,
    output logic                  done_o
);
    import pwo_pkg::*;

    localparam beat_idx_t last_beat = beat_idx_t'(`PWO_N/`PWO_LANES - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain,
        st_finish
    } state_e;

    state_e     state_q, state_d;
    pwo_mode_e  mode_q;
    logic       acc_q;
    pwo_bases_t bases_q;
    beat_idx_t  issue_cnt_q;
    beat_idx_t  wr_cnt_q;
    logic       start;
    logic       issue_fire;
    logic       add_c;

    assign start      = enable_i && !busy_o;
    assign issue_fire = (state_q == st_issue) && sampler_valid_i;
    // Old c is only folded in for an accumulating multiply
    assign add_c      = (mode_q == pwo_mul) && acc_q;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle, st_finish: begin
                state_d = start ? st_issue : st_idle;
            end
            st_issue: begin
                if (issue_fire && issue_cnt_q == last_beat) begin
                    state_d = st_drain;
                end
            end
            st_drain: begin
                if (wr_strobe_i && wr_cnt_q == last_beat) begin
                    state_d = st_finish;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= st_idle;
            mode_q      <= pwo_mul;
            acc_q       <= 1'b0;
            bases_q     <= '0;
            issue_cnt_q <= '0;
            wr_cnt_q    <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                mode_q      <= mode_i;
                acc_q       <= accumulate_i;
                bases_q     <= bases_i;
                issue_cnt_q <= '0;
                wr_cnt_q    <= '0;
            end else begin
                if (issue_fire) begin
                    issue_cnt_q <= issue_cnt_q + 1'b1;
                end
                // Writes land while still issuing, so count them in any state
                if (wr_strobe_i) begin
                    wr_cnt_q <= wr_cnt_q + 1'b1;
                end
            end
        end
    end

    // ====================
    // Requests and tag
    // ====================
    always_comb begin
        rd_req_a_o.en   = issue_fire;
        rd_req_a_o.addr = bases_q.base_a + mem_addr_t'(issue_cnt_q);
        rd_req_b_o.en   = issue_fire;
        rd_req_b_o.addr = bases_q.base_b + mem_addr_t'(issue_cnt_q);
        rd_req_c_o.en   = issue_fire && add_c;
        rd_req_c_o.addr = bases_q.base_c + mem_addr_t'(issue_cnt_q);

        tag_o.valid    = issue_fire;
        tag_o.op.mode  = mode_q;
        tag_o.op.add_c = add_c;
        tag_o.wr_addr  = bases_q.base_c + mem_addr_t'(issue_cnt_q);
    end

    assign busy_o = (state_q == st_issue) || (state_q == st_drain);
    assign done_o = (state_q == st_finish);

endmodule

/* design/pwo_operand_unpack.sv */
/*
 * Operand unpacker
 * Lines the beat tag up with returned memory data and splits
 * each word into per-lane coefficients
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_operand_unpack (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  pwo_pkg::beat_tag_t                    tag_i,
    input  pwo_pkg::mem_word_t                    rd_data_a_i,
    input  pwo_pkg::mem_word_t                    rd_data_b_i,
    input  pwo_pkg::mem_word_t                    rd_data_c_i,
    output pwo_pkg::lane_in_t [`PWO_LANES-1:0]    lane_o
);
    import pwo_pkg::*;

    beat_tag_t                  tag_d1_q;
    beat_tag_t                  tag_d2_q;
    coeff_t [`PWO_LANES-1:0]    a_q;
    coeff_t [`PWO_LANES-1:0]    b_q;
    coeff_t [`PWO_LANES-1:0]    c_q;

    // Memory answers one cycle after the request, so hold the tag one extra
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_d1_q <= '0;
            tag_d2_q <= '0;
        end else begin
            tag_d1_q <= tag_i;
            tag_d2_q <= tag_d1_q;
        end
    end

    // Slot pad bit is dropped here
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            a_q[i] <= rd_data_a_i[i*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH];
            b_q[i] <= rd_data_b_i[i*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH];
            c_q[i] <= rd_data_c_i[i*`PWO_SLOT_WIDTH +: `PWO_COEFF_WIDTH];
        end
    end

    always_comb begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            lane_o[i].tag = tag_d2_q;
            lane_o[i].a   = a_q[i];
            lane_o[i].b   = b_q[i];
            lane_o[i].c   = c_q[i];
        end
    end

endmodule

/* design/pwo_lane.sv */
/*
 * Modular arithmetic lane
 * Stage one forms a*b, a+b or a-b+q; stage two reduces mod q
 * and optionally folds in the old c
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_lane (
    input  logic                clk,
    input  logic                reset_n,
    input  pwo_pkg::lane_in_t   in_i,
    output pwo_pkg::lane_out_t  out_o
);
    import pwo_pkg::*;

    // One fold step using 2^23 = 2^13 - 1 (mod q)
    function automatic logic [36:0] fold(input logic [45:0] x);
        logic [22:0] hi;
        logic [22:0] lo;
        hi = x[45:23];
        lo = x[22:0];
        return 37'({hi, 13'd0}) + 37'(lo) - 37'(hi);
    endfunction

    // Input is below 2q
    function automatic coeff_t csub(input logic [23:0] v);
        logic [23:0] d;
        d = v - 24'(`PWO_Q);
        return (v >= 24'(`PWO_Q)) ? d[22:0] : v[22:0];
    endfunction

    beat_tag_t    s1_tag_q;
    logic [45:0]  s1_val_d, s1_val_q;
    coeff_t       s1_c_q;
    beat_tag_t    s2_tag_q;
    coeff_t       s2_res_q;
    logic [36:0]  f1, f2, f3;
    coeff_t       red;
    logic [23:0]  sum_c;
    coeff_t       res_d;

    // ====================
    // Stage one
    // ====================
    always_comb begin
        case (in_i.tag.op.mode)
            pwo_mul: s1_val_d = 46'(in_i.a) * 46'(in_i.b);
            pwo_add: s1_val_d = 46'(in_i.a) + 46'(in_i.b);
            pwo_sub: s1_val_d = 46'(in_i.a) + 46'(`PWO_Q) - 46'(in_i.b);
            default: s1_val_d = '0;
        endcase
    end

    // ====================
    // Stage two
    // ====================
    // Three folds bring any product below 2^23 + 2^18, under 2q
    always_comb begin
        f1    = fold(s1_val_q);
        f2    = fold(46'(f1));
        f3    = fold(46'(f2));
        red   = csub(f3[23:0]);
        sum_c = {1'b0, red} + {1'b0, s1_c_q};
        res_d = s1_tag_q.op.add_c ? csub(sum_c) : red;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_tag_q <= '0;
            s2_tag_q <= '0;
        end else begin
            s1_tag_q <= in_i.tag;
            s2_tag_q <= s1_tag_q;
        end
    end

    always_ff @(posedge clk) begin
        s1_val_q <= s1_val_d;
        s1_c_q   <= in_i.c;
        s2_res_q <= res_d;
    end

    assign out_o.tag = s2_tag_q;
    assign out_o.res = s2_res_q;

endmodule

/* design/pwo_result_pack.sv */
/*
 * Result packer
 * Gathers the lane results into one zero-padded memory word
 * and issues the write for the beat
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_result_pack (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  pwo_pkg::lane_out_t [`PWO_LANES-1:0]    lane_i,
    output pwo_pkg::mem_req_t                      wr_req_o,
    output pwo_pkg::mem_word_t                     wr_data_o
);
    import pwo_pkg::*;

    mem_req_t   wr_req_q;
    mem_word_t  data_q;

    // All lanes carry the same tag, lane 0 speaks for the beat
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_req_q <= '0;
        end else begin
            wr_req_q.en   <= lane_i[0].tag.valid;
            wr_req_q.addr <= lane_i[0].tag.wr_addr;
        end
    end

    // Top bit of each slot stays zero
    always_ff @(posedge clk) begin
        for (int i = 0; i < `PWO_LANES; i++) begin
            data_q[i*`PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] <=
                `PWO_SLOT_WIDTH'(lane_i[i].res);
        end
    end

    assign wr_req_o  = wr_req_q;
    assign wr_data_o = data_q;

endmodule

/* design/pwo_top.sv */
/*
 * Pointwise engine top
 * Sequencer, operand unpacker, four arithmetic lanes and result packer
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 enable_i,
    input  pwo_pkg::pwo_mode_e   mode_i,
    input  logic                 accumulate_i,
    input  pwo_pkg::pwo_bases_t  bases_i,
    input  logic                 sampler_valid_i,
    output pwo_pkg::mem_req_t    rd_req_a_o,
    output pwo_pkg::mem_req_t    rd_req_b_o,
    output pwo_pkg::mem_req_t    rd_req_c_o,
    input  pwo_pkg::mem_word_t   rd_data_a_i,
    input  pwo_pkg::mem_word_t   rd_data_b_i,
    input  pwo_pkg::mem_word_t   rd_data_c_i,
    output pwo_pkg::mem_req_t    wr_req_o,
    output pwo_pkg::mem_word_t   wr_data_o,
    output logic                 busy_o,
    output logic                 done_o
);
    import pwo_pkg::*;

    beat_tag_t                    tag;
    lane_in_t  [`PWO_LANES-1:0]   lane_in;
    lane_out_t [`PWO_LANES-1:0]   lane_out;

    pwo_ctrl i_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .enable_i        (enable_i),
        .mode_i          (mode_i),
        .accumulate_i    (accumulate_i),
        .bases_i         (bases_i),
        .sampler_valid_i (sampler_valid_i),
        .wr_strobe_i     (wr_req_o.en),
        .rd_req_a_o      (rd_req_a_o),
        .rd_req_b_o      (rd_req_b_o),
        .rd_req_c_o      (rd_req_c_o),
        .tag_o           (tag),
        .busy_o          (busy_o),
        .done_o          (done_o)
    );

    pwo_operand_unpack i_unpack (
        .clk         (clk),
        .reset_n     (reset_n),
        .tag_i       (tag),
        .rd_data_a_i (rd_data_a_i),
        .rd_data_b_i (rd_data_b_i),
        .rd_data_c_i (rd_data_c_i),
        .lane_o      (lane_in)
    );

    for (genvar i = 0; i < `PWO_LANES; i++) begin : g_lane
        pwo_lane i_lane (
            .clk     (clk),
            .reset_n (reset_n),
            .in_i    (lane_in[i]),
            .out_o   (lane_out[i])
        );
    end

    pwo_result_pack i_pack (
        .clk       (clk),
        .reset_n   (reset_n),
        .lane_i    (lane_out),
        .wr_req_o  (wr_req_o),
        .wr_data_o (wr_data_o)
    );

endmodule

/* bench/pwo_tb.sv */
/*
 * Pointwise engine testbench
 * Random passes in every mode against a memory model and a reference
 * model, with sampler stalls, write timing and control checks
 */
`timescale 1ns/1ns
`include "pwo_config.svh"

module pwo_tb;
    import pwo_pkg::*;

    localparam int BEATS       = `PWO_N / `PWO_LANES;
    localparam int PASSES      = 8;
    // Worst case for one pass at 50% sampler duty, with margin
    localparam int PASS_CYCLES = 400;
    localparam int MAX_CYCLES  = PASSES * PASS_CYCLES + 800;
    localparam int MEM_WORDS   = 1 << `PWO_ADDR_WIDTH;
    localparam longint unsigned Q = 64'(`PWO_Q);

    logic       clk;
    logic       reset_n;
    logic       enable;
    pwo_mode_e  mode;
    logic       accumulate;
    pwo_bases_t bases;
    logic       sampler_valid;
    mem_req_t   rd_req_a, rd_req_b, rd_req_c, wr_req;
    mem_word_t  rd_data_a = '0;
    mem_word_t  rd_data_b = '0;
    mem_word_t  rd_data_c = '0;
    mem_word_t  wr_data;
    logic       busy, done;

    mem_word_t  mem [MEM_WORDS];
    mem_word_t  exp_word [BEATS];
    int         wr_count [BEATS];
    int         rd_cycle [BEATS];
    pwo_mode_e  cur_mode = pwo_mul;
    logic       cur_acc = 1'b0;
    pwo_bases_t cur_bases = '0;
    int         cycle = 0;
    int         last_wr_cycle = 0;
    int         done_count = 0;
    logic       post_done = 1'b0;
    logic       busy_prev = 1'b0;
    int         errors = 0;
    int         passes = 0;
    int         words_checked = 0;

    pwo_top i_dut (
        .clk             (clk),
        .reset_n         (reset_n),
        .enable_i        (enable),
        .mode_i          (mode),
        .accumulate_i    (accumulate),
        .bases_i         (bases),
        .sampler_valid_i (sampler_valid),
        .rd_req_a_o      (rd_req_a),
        .rd_req_b_o      (rd_req_b),
        .rd_req_c_o      (rd_req_c),
        .rd_data_a_i     (rd_data_a),
        .rd_data_b_i     (rd_data_b),
        .rd_data_c_i     (rd_data_c),
        .wr_req_o        (wr_req),
        .wr_data_o       (wr_data),
        .busy_o          (busy),
        .done_o          (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic show_mismatch(input string name, input int idx, input mem_word_t e,
                                 input mem_word_t g);
        $display("ERR %0t %s[%0d] exp=%h got=%h", $time, name, idx, e, g);
        errors++;
    endtask

    task automatic raise_fault(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors++;
    endtask

    // Mostly uniform below q, with the edge values mixed in
    function automatic coeff_t random_coeff();
        int unsigned pick;
        pick = $urandom % 16;
        if (pick == 0) return '0;
        if (pick == 1) return coeff_t'(Q - 1);
        return coeff_t'($urandom % 32'(`PWO_Q));
    endfunction

    // Reference result for one coefficient
    function automatic coeff_t model_coeff(input pwo_mode_e m, input logic acc,
                                           input coeff_t a, input coeff_t b, input coeff_t c);
        longint unsigned r;
        case (m)
            pwo_mul: begin
                r = (64'(a) * 64'(b)) % Q;
                if (acc) r = (r + 64'(c)) % Q;
            end
            pwo_add: r = (64'(a) + 64'(b)) % Q;
            default: r = (64'(a) + Q - 64'(b)) % Q;
        endcase
        return coeff_t'(r);
    endfunction

    // ====================
    // Memory model and monitor
    // ====================
    always @(posedge clk) begin
        int off;
        cycle <= cycle + 1;
        if (reset_n) begin
            if (rd_req_a.en) rd_data_a <= mem[rd_req_a.addr];
            if (rd_req_b.en) rd_data_b <= mem[rd_req_b.addr];
            if (rd_req_c.en) rd_data_c <= mem[rd_req_c.addr];
            if (wr_req.en) mem[wr_req.addr] <= wr_data;

            if (rd_req_b.en && !sampler_valid)
                raise_fault("read of b while sampler_valid_i low");
            if (rd_req_a.en) begin
                off = int'(rd_req_a.addr) - int'(cur_bases.base_a);
                if (off < 0 || off >= BEATS) raise_fault("read of a outside its window");
                else rd_cycle[off] = cycle;
                if (!rd_req_b.en || int'(rd_req_b.addr) - int'(cur_bases.base_b) != off)
                    raise_fault("read of b not paired with read of a");
                if (rd_req_c.en && int'(rd_req_c.addr) - int'(cur_bases.base_c) != off)
                    raise_fault("read of c not paired with read of a");
            end
            if (rd_req_c.en != (rd_req_a.en && cur_mode == pwo_mul && cur_acc))
                raise_fault("c read enable wrong for the pass mode");

            if (wr_req.en) begin
                off = int'(wr_req.addr) - int'(cur_bases.base_c);
                last_wr_cycle = cycle;
                if (post_done) raise_fault("write request after done_o");
                else if (off < 0 || off >= BEATS) raise_fault("write outside the c window");
                else begin
                    wr_count[off]++;
                    if (cycle - rd_cycle[off] != 5)
                        show_mismatch("wr_req_o latency", off, 96'(5),
                                      96'(cycle - rd_cycle[off]));
                end
            end

            if (done) begin
                done_count++;
                post_done = 1'b1;
                if (busy || !busy_prev) raise_fault("done_o not in the cycle busy_o fell");
                if (cycle - last_wr_cycle != 1)
                    raise_fault("done_o not one cycle after the last write request");
            end else if (busy_prev && !busy) begin
                raise_fault("busy_o fell without done_o");
            end
            busy_prev = busy;
        end
    end

    task automatic run_pass(input pwo_mode_e m, input logic acc, input logic stall);
        pwo_bases_t bb;
        mem_word_t  wa, wb, wc, we;
        coeff_t     a, b, c;
        int         k;
        // Three disjoint windows so a stray write is always caught
        bb.base_a = mem_addr_t'($urandom % 8000);
        bb.base_b = mem_addr_t'(8192 + $urandom % 8000);
        bb.base_c = mem_addr_t'(16384 + $urandom % 8000);
        for (int w = 0; w < BEATS; w++) begin
            wa = '0;
            wb = '0;
            wc = '0;
            we = '0;
            for (int l = 0; l < `PWO_LANES; l++) begin
                a = random_coeff();
                b = random_coeff();
                c = random_coeff();
                wa[l*`PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, a};
                wb[l*`PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, b};
                wc[l*`PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, c};
                we[l*`PWO_SLOT_WIDTH +: `PWO_SLOT_WIDTH] = {1'b0, model_coeff(m, acc, a, b, c)};
            end
            mem[bb.base_a + mem_addr_t'(w)] <= wa;
            mem[bb.base_b + mem_addr_t'(w)] <= wb;
            mem[bb.base_c + mem_addr_t'(w)] <= wc;
            exp_word[w] = we;
            wr_count[w] = 0;
        end

        @(negedge clk);
        cur_mode   = m;
        cur_acc    = acc;
        cur_bases  = bb;
        done_count = 0;
        post_done  = 1'b0;
        enable     = 1'b1;
        mode       = m;
        accumulate = acc;
        bases      = bb;
        @(negedge clk);
        k = 0;
        while (done_count == 0) begin
            if (k == 0 && !busy) raise_fault("busy_o did not rise after the start strobe");
            sampler_valid = stall ? 1'($urandom % 2) : 1'b1;
            // Second start mid pass with other settings, must be ignored
            if (k == 10) begin
                enable     = 1'b1;
                mode       = pwo_mode_e'($urandom % 3);
                accumulate = ~acc;
                bases      = {bb.base_c, bb.base_a, bb.base_b};
            end else begin
                enable = 1'b0;
            end
            k++;
            @(negedge clk);
        end
        enable        = 1'b0;
        sampler_valid = 1'b0;
        repeat (8) @(negedge clk);

        if (done_count != 1) raise_fault("done_o did not pulse exactly once in the pass");
        for (int w = 0; w < BEATS; w++) begin
            if (wr_count[w] != 1) raise_fault("c word not written exactly once");
            if (mem[bb.base_c + mem_addr_t'(w)] !== exp_word[w])
                show_mismatch("wr_data_o word", w, exp_word[w], mem[bb.base_c + mem_addr_t'(w)]);
            words_checked++;
        end
        passes++;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        logic add_acc;
        logic sub_acc;
        void'($urandom(32'h329c_5951));
        reset_n       = 1'b0;
        enable        = 1'b0;
        mode          = pwo_mul;
        accumulate    = 1'b0;
        bases         = '0;
        sampler_valid = 1'b0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        if (busy || done || rd_req_a.en || rd_req_b.en || rd_req_c.en || wr_req.en)
            raise_fault("outputs not idle after reset");

        // Stalled add and sub passes take the other accumulate value
        add_acc = 1'($urandom % 2);
        sub_acc = 1'($urandom % 2);

        run_pass(pwo_mul, 1'b0, 1'b0);
        run_pass(pwo_mul, 1'b1, 1'b0);
        run_pass(pwo_add, add_acc, 1'b0);
        run_pass(pwo_sub, sub_acc, 1'b0);
        run_pass(pwo_mul, 1'b0, 1'b1);
        run_pass(pwo_mul, 1'b1, 1'b1);
        run_pass(pwo_add, ~add_acc, 1'b1);
        run_pass(pwo_sub, ~sub_acc, 1'b1);

        $display("Passes: %0d, words checked: %0d, errors: %0d", passes, words_checked, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle < MAX_CYCLES) @(negedge clk);
        $display("Timeout: run not finished after %0d cycles", MAX_CYCLES);
        $display("Passes: %0d, words checked: %0d, errors: %0d", passes, words_checked, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/pwo_pkg.sv
design/pwo_ctrl.sv
design/pwo_operand_unpack.sv
design/pwo_lane.sv
design/pwo_result_pack.sv
design/pwo_top.sv
bench/pwo_tb.sv

/* Makefile */
# Verilator build and run for the pointwise engine testbench

VERILATOR ?= verilator
TOP       ?= pwo_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
